// ==== verilog/subway_map_pkg.sv ====
package subway_map_pkg;

    // map geometry
    localparam int num_lanes = 4;
    localparam int default_map_cols = 64;
    localparam int default_train_gap = 8;  // train column every 8th

    typedef logic [1:0] lane_t;

    // one map cell
    typedef enum logic [1:0] {
        cell_road  = 2'd0,
        cell_low   = 2'd1,  // jumpable
        cell_high  = 2'd2,
        cell_train = 2'd3
    } cell_t;

endpackage

// ==== verilog/subway_ctrl_pkg.sv ====
package subway_ctrl_pkg;

    // streamed action codes
    typedef enum logic [1:0] {
        act_forward = 2'd0,
        act_right   = 2'd1,  // lane + 1
        act_left    = 2'd2,  // lane - 1
        act_jump    = 2'd3
    } action_t;

    // controller states
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_load = 2'd1,
        st_plan = 2'd2,
        st_emit = 2'd3
    } run_state_t;

endpackage

// ==== verilog/map_buffer.sv ====
`timescale 1ns/1ns

module map_buffer #(
    parameter int map_cols = subway_map_pkg::default_map_cols
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  logic                                                in_valid,
    input  subway_map_pkg::lane_t                               init,
    input  subway_map_pkg::cell_t                               in0,
    input  subway_map_pkg::cell_t                               in1,
    input  subway_map_pkg::cell_t                               in2,
    input  subway_map_pkg::cell_t                               in3,
    input  logic                                                wr_en,
    input  logic [$clog2(map_cols)-1:0]                         col_idx,
    input  logic [$clog2(map_cols)-1:0]                         rd_next_col,
    input  logic [$clog2(map_cols)-1:0]                         rd_train_col,
    output logic                                                ld_valid,
    output subway_map_pkg::cell_t [subway_map_pkg::num_lanes-1:0] ld_cells,
    output subway_map_pkg::lane_t                               start_lane,
    output subway_map_pkg::cell_t [subway_map_pkg::num_lanes-1:0] next_cells,
    output subway_map_pkg::cell_t [subway_map_pkg::num_lanes-1:0] train_cells
);

    // one column per entry with lane 0 in slice 0
    subway_map_pkg::cell_t [subway_map_pkg::num_lanes-1:0] store [map_cols];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ld_valid   <= 1'b0;
            start_lane <= '0;
        end else begin
            ld_valid <= in_valid;
            if (in_valid && !ld_valid) begin
                start_lane <= init;  // first column of the frame
            end
        end
    end

    always_ff @(posedge clk) begin
        ld_cells[0] <= in0;
        ld_cells[1] <= in1;
        ld_cells[2] <= in2;
        ld_cells[3] <= in3;
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            store[col_idx] <= ld_cells;
        end
    end

    assign next_cells  = store[rd_next_col];   // column t+1
    assign train_cells = store[rd_train_col];  // upcoming train column

    // no write may follow the last column
    a_wr_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        wr_en && int'(col_idx) == map_cols - 1 |=> !wr_en)
        else $error("column write past end of map");

endmodule

// ==== verilog/run_ctrl.sv ====
`timescale 1ns/1ns

module run_ctrl #(
    parameter int map_cols = 64
) (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        ld_valid,
    output logic                        wr_en,
    output logic [$clog2(map_cols)-1:0] col_idx,
    output logic                        plan_start,
    output logic                        step_en,
    output logic                        out_valid
);

    localparam int cw = $clog2(map_cols);

    subway_ctrl_pkg::run_state_t state;
    subway_ctrl_pkg::run_state_t state_nxt;
    logic [cw-1:0] cnt;  // column index in load, step index in emit
    logic          last_step;

    assign last_step  = cnt == cw'(map_cols - 2);
    assign wr_en      = ld_valid && (state == subway_ctrl_pkg::st_idle ||
                                     state == subway_ctrl_pkg::st_load);
    assign plan_start = state == subway_ctrl_pkg::st_plan;
    assign step_en    = state == subway_ctrl_pkg::st_emit;
    assign col_idx    = cnt;

    always_comb begin
        state_nxt = state;
        case (state)
            subway_ctrl_pkg::st_idle: begin
                if (ld_valid) begin
                    state_nxt = subway_ctrl_pkg::st_load;
                end
            end
            subway_ctrl_pkg::st_load: begin
                if (!ld_valid) begin
                    state_nxt = subway_ctrl_pkg::st_plan;
                end
            end
            subway_ctrl_pkg::st_plan: state_nxt = subway_ctrl_pkg::st_emit;
            subway_ctrl_pkg::st_emit: begin
                if (last_step) begin
                    state_nxt = subway_ctrl_pkg::st_idle;
                end
            end
            default: state_nxt = subway_ctrl_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= subway_ctrl_pkg::st_idle;
            cnt       <= '0;
            out_valid <= 1'b0;
        end else begin
            state     <= state_nxt;
            out_valid <= step_en;  // action register lags one cycle
            if (wr_en) begin
                cnt <= cnt + 1'b1;
            end else if (plan_start || (step_en && last_step)) begin
                cnt <= '0;
            end else if (step_en) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    // one burst of map_cols-1 actions per frame
    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(out_valid) |-> ##(map_cols - 1) !out_valid)
        else $error("out_valid burst longer than map_cols-1");

endmodule

// ==== verilog/move_planner.sv ====
`timescale 1ns/1ns

module move_planner #(
    parameter int map_cols  = 64,
    parameter int train_gap = 8
) (
    input  logic                                                clk,
    input  logic                                                rst_n,
    input  subway_map_pkg::lane_t                               start_lane,
    input  logic                                                plan_start,
    input  logic                                                step_en,
    input  logic [$clog2(map_cols)-1:0]                         col_idx,
    input  subway_map_pkg::cell_t [subway_map_pkg::num_lanes-1:0] next_cells,
    input  subway_map_pkg::cell_t [subway_map_pkg::num_lanes-1:0] train_cells,
    output logic [$clog2(map_cols)-1:0]                         rd_next_col,
    output logic [$clog2(map_cols)-1:0]                         rd_train_col,
    output subway_ctrl_pkg::action_t                            out
);

    localparam int cw = $clog2(map_cols);

    subway_map_pkg::lane_t    cur_lane;
    subway_map_pkg::lane_t    up_lane;
    subway_map_pkg::lane_t    dn_lane;
    subway_map_pkg::lane_t    free_lane;
    subway_map_pkg::lane_t    target;
    subway_map_pkg::lane_t    nxt_lane;
    subway_ctrl_pkg::action_t choice;
    int                       look_col;
    int                       train_col;
    logic                     train_ahead;

    assign look_col    = int'(col_idx) + 1;
    // round up to the next multiple of train_gap
    assign train_col   = ((look_col + train_gap - 1) / train_gap) * train_gap;
    assign train_ahead = train_col < map_cols;

    assign rd_next_col  = cw'(look_col);
    assign rd_train_col = train_ahead ? cw'(train_col) : '0;

    assign up_lane = cur_lane + 2'd1;
    assign dn_lane = cur_lane - 2'd1;

    // lowest road lane in the train column
    always_comb begin
        free_lane = cur_lane;
        for (int i = subway_map_pkg::num_lanes - 1; i >= 0; i--) begin
            if (train_cells[i] == subway_map_pkg::cell_road) begin
                free_lane = subway_map_pkg::lane_t'(i);
            end
        end
    end

    assign target = train_ahead ? free_lane : cur_lane;  // hold lane once no trains are left

    always_comb begin
        choice   = subway_ctrl_pkg::act_forward;
        nxt_lane = cur_lane;
        if (next_cells[cur_lane] == subway_map_pkg::cell_low) begin
            choice = subway_ctrl_pkg::act_jump;
        end else if (target > cur_lane && next_cells[up_lane] == subway_map_pkg::cell_road) begin
            choice   = subway_ctrl_pkg::act_right;
            nxt_lane = up_lane;
        end else if (target < cur_lane && next_cells[dn_lane] == subway_map_pkg::cell_road) begin
            choice   = subway_ctrl_pkg::act_left;
            nxt_lane = dn_lane;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_lane <= '0;
            out      <= subway_ctrl_pkg::act_forward;
        end else begin
            if (plan_start) begin
                cur_lane <= start_lane;
            end else if (step_en) begin
                cur_lane <= nxt_lane;
            end
            if (step_en) begin
                out <= choice;
            end else begin
                out <= subway_ctrl_pkg::act_forward;  // quiet between bursts
            end
        end
    end

    // cell entered by any step must not be a train
    a_no_train_entry: assert property (@(posedge clk) disable iff (!rst_n)
        step_en |-> next_cells[nxt_lane] != subway_map_pkg::cell_train)
        else $error("step into a train cell");

endmodule

// ==== verilog/subway_top.sv ====
`timescale 1ns/1ns

module subway_top #(
    parameter int map_cols  = subway_map_pkg::default_map_cols,
    parameter int train_gap = subway_map_pkg::default_train_gap
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  subway_map_pkg::lane_t    init,
    input  subway_map_pkg::cell_t    in0,
    input  subway_map_pkg::cell_t    in1,
    input  subway_map_pkg::cell_t    in2,
    input  subway_map_pkg::cell_t    in3,
    output logic                     out_valid,
    output subway_ctrl_pkg::action_t out
);

    localparam int cw = $clog2(map_cols);

    logic                                                ld_valid;
    subway_map_pkg::cell_t [subway_map_pkg::num_lanes-1:0] ld_cells;
    subway_map_pkg::lane_t                               start_lane;
    logic                                                wr_en;
    logic [cw-1:0]                                       col_idx;
    logic                                                plan_start;
    logic                                                step_en;
    logic [cw-1:0]                                       rd_next_col;
    logic [cw-1:0]                                       rd_train_col;
    subway_map_pkg::cell_t [subway_map_pkg::num_lanes-1:0] next_cells;
    subway_map_pkg::cell_t [subway_map_pkg::num_lanes-1:0] train_cells;

    map_buffer #(.map_cols(map_cols)) u_map_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .init         (init),
        .in0          (in0),
        .in1          (in1),
        .in2          (in2),
        .in3          (in3),
        .wr_en        (wr_en),
        .col_idx      (col_idx),
        .rd_next_col  (rd_next_col),
        .rd_train_col (rd_train_col),
        .ld_valid     (ld_valid),
        .ld_cells     (ld_cells),
        .start_lane   (start_lane),
        .next_cells   (next_cells),
        .train_cells  (train_cells)
    );

    run_ctrl #(.map_cols(map_cols)) u_run_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .ld_valid   (ld_valid),
        .wr_en      (wr_en),
        .col_idx    (col_idx),
        .plan_start (plan_start),
        .step_en    (step_en),
        .out_valid  (out_valid)
    );

    move_planner #(.map_cols(map_cols), .train_gap(train_gap)) u_move_planner (
        .clk          (clk),
        .rst_n        (rst_n),
        .start_lane   (start_lane),
        .plan_start   (plan_start),
        .step_en      (step_en),
        .col_idx      (col_idx),
        .next_cells   (next_cells),
        .train_cells  (train_cells),
        .rd_next_col  (rd_next_col),
        .rd_train_col (rd_train_col),
        .out          (out)
    );

endmodule

// ==== sim/tb_subway_model.svh ====
`ifndef TB_SUBWAY_MODEL_SVH
`define TB_SUBWAY_MODEL_SVH

// galois lfsr, one step per bit taken
function automatic logic rand_bit();
    logic lsb;
    lsb = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (lsb) begin
        lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return lsb;
endfunction

function automatic int rand_bits(int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
        v = (v << 1) | int'(rand_bit());
    end
    return v;
endfunction

// odd columns all road, every train column keeps at least one road lane
function automatic void gen_random_map();
    int c;
    int l;
    int v;
    for (c = 0; c < map_cols; c++) begin
        for (l = 0; l < num_lanes; l++) begin
            frame_map[c][l] = subway_map_pkg::cell_road;
        end
        if (c == 0 || c % 2 == 1) begin
            continue;
        end
        if (c % train_gap == 0) begin
            for (l = 0; l < num_lanes; l++) begin
                frame_map[c][l] = (rand_bits(2) != 0) ? subway_map_pkg::cell_train
                                                      : subway_map_pkg::cell_road;
            end
            frame_map[c][rand_bits(2)] = subway_map_pkg::cell_road;
        end else begin
            for (l = 0; l < num_lanes; l++) begin
                v = rand_bits(2);
                frame_map[c][l] = (v == 3) ? subway_map_pkg::cell_road
                                           : subway_map_pkg::cell_t'(v);
            end
        end
    end
endfunction

// expected action stream for frame_map, greedy rule applied step by step
function automatic void model_actions(int start);
    int lane;
    int t;
    int col;
    int tcol;
    int tgt;
    int l;
    logic found;
    subway_ctrl_pkg::action_t act;
    lane = start;
    for (t = 0; t < num_steps; t++) begin
        col  = t + 1;
        tcol = col;
        while (tcol % train_gap != 0) begin
            tcol++;
        end
        tgt   = lane;  // held once no train column is left
        found = 1'b0;
        if (tcol < map_cols) begin
            for (l = 0; l < num_lanes; l++) begin
                if (!found && frame_map[tcol][l] == subway_map_pkg::cell_road) begin
                    tgt   = l;
                    found = 1'b1;
                end
            end
        end
        act = subway_ctrl_pkg::act_forward;
        if (frame_map[col][lane] == subway_map_pkg::cell_low) begin
            act = subway_ctrl_pkg::act_jump;
        end else if (tgt > lane && frame_map[col][lane + 1] == subway_map_pkg::cell_road) begin
            act  = subway_ctrl_pkg::act_right;
            lane = lane + 1;
        end else if (tgt < lane && frame_map[col][lane - 1] == subway_map_pkg::cell_road) begin
            act  = subway_ctrl_pkg::act_left;
            lane = lane - 1;
        end
        exp_q.push_back(act);
    end
endfunction

`endif

// ==== sim/tb_subway.sv ====
`timescale 1ns/1ns

module tb_subway;

    localparam int map_cols     = subway_map_pkg::default_map_cols;
    localparam int train_gap    = subway_map_pkg::default_train_gap;
    localparam int num_lanes    = subway_map_pkg::num_lanes;
    localparam int num_steps    = map_cols - 1;
    localparam int reset_cycles = 16;
    localparam int num_frames   = 8;
    localparam int frame_cycles = 140;  // load, plan, emit, short gap
    localparam int cycle_limit  = (reset_cycles + num_frames * frame_cycles) * 4 / 3;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    subway_map_pkg::lane_t    init;
    subway_map_pkg::cell_t    in0;
    subway_map_pkg::cell_t    in1;
    subway_map_pkg::cell_t    in2;
    subway_map_pkg::cell_t    in3;
    logic                     out_valid;
    subway_ctrl_pkg::action_t out;

    logic [31:0]              lfsr_state;
    subway_map_pkg::cell_t    frame_map [map_cols][num_lanes];
    subway_ctrl_pkg::action_t exp_q [$];
    subway_ctrl_pkg::action_t exp_out;
    subway_map_pkg::lane_t    frame_init;
    logic                     started;
    logic                     was_valid;
    int                       burst_cnt;
    int                       trk_lane;  // lane rebuilt from observed actions
    int                       cycles;
    int                       action_errs;
    int                       timing_errs;
    int                       lane_errs;
    int                       other_errs;

    `include "tb_subway_model.svh"

    subway_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .init      (init),
        .in0       (in0),
        .in1       (in1),
        .in2       (in2),
        .in3       (in3),
        .out_valid (out_valid),
        .out       (out)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // low cell in the start lane on every even non-train column
    function automatic void gen_jump_map(int lane);
        int c;
        int l;
        for (c = 0; c < map_cols; c++) begin
            for (l = 0; l < num_lanes; l++) begin
                frame_map[c][l] = subway_map_pkg::cell_road;
                if (c > 0 && c % 2 == 0 && l != lane) begin
                    frame_map[c][l] = (c % train_gap == 0) ? subway_map_pkg::cell_train
                                                           : subway_map_pkg::cell_high;
                end else if (c % 2 == 0 && c % train_gap != 0 && l == lane) begin
                    frame_map[c][l] = subway_map_pkg::cell_low;
                end
            end
        end
    endfunction

    // single free lane per train column swapping between the outer lanes
    function automatic void gen_lateral_map();
        int c;
        int l;
        int free_l;
        for (c = 0; c < map_cols; c++) begin
            free_l = ((c / train_gap) % 2 == 1) ? num_lanes - 1 : 0;
            for (l = 0; l < num_lanes; l++) begin
                if (c > 0 && c % train_gap == 0 && l != free_l) begin
                    frame_map[c][l] = subway_map_pkg::cell_train;
                end else begin
                    frame_map[c][l] = subway_map_pkg::cell_road;
                end
            end
        end
    endfunction

    task automatic idle_cycles(int n);
        repeat (n) @(negedge clk);
    endtask

    // starts and ends on a falling edge
    task automatic drive_frame(subway_map_pkg::lane_t start);
        int c;
        for (c = 0; c < map_cols; c++) begin
            in_valid = 1'b1;
            init     = start;
            in0      = frame_map[c][0];
            in1      = frame_map[c][1];
            in2      = frame_map[c][2];
            in3      = frame_map[c][3];
            @(negedge clk);
        end
        in_valid = 1'b0;
        in0      = subway_map_pkg::cell_road;
        in1      = subway_map_pkg::cell_road;
        in2      = subway_map_pkg::cell_road;
        in3      = subway_map_pkg::cell_road;
    endtask

    task automatic wait_burst_end();
        while (!out_valid) @(negedge clk);
        while (out_valid) @(negedge clk);
    endtask

    task automatic run_frame(subway_map_pkg::lane_t start);
        started    = 1'b1;
        frame_init = start;
        model_actions(int'(start));
        drive_frame(start);
        wait_burst_end();
    endtask

    initial begin
        int f;
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        init        = '0;
        in0         = subway_map_pkg::cell_road;
        in1         = subway_map_pkg::cell_road;
        in2         = subway_map_pkg::cell_road;
        in3         = subway_map_pkg::cell_road;
        lfsr_state  = 32'h85ad_de18;
        exp_out     = subway_ctrl_pkg::act_forward;
        frame_init  = '0;
        started     = 1'b0;
        was_valid   = 1'b0;
        burst_cnt   = 0;
        trk_lane    = 0;
        action_errs = 0;
        timing_errs = 0;
        lane_errs   = 0;
        other_errs  = 0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
        idle_cycles(4);
        for (f = 0; f < 4; f++) begin
            gen_random_map();
            run_frame(subway_map_pkg::lane_t'(rand_bits(2)));
            idle_cycles(3);
        end
        gen_jump_map(2);
        run_frame(subway_map_pkg::lane_t'(2));
        idle_cycles(3);
        gen_lateral_map();
        run_frame(subway_map_pkg::lane_t'(0));  // free lane three lanes away
        idle_cycles(3);
        gen_random_map();  // back to back pair
        run_frame(subway_map_pkg::lane_t'(rand_bits(2)));
        gen_random_map();
        run_frame(subway_map_pkg::lane_t'(rand_bits(2)));
        idle_cycles(4);
        if (exp_q.size() != 0) begin
            other_errs++;
            $display("%0d expected actions never came out", exp_q.size());
        end
        $display("errors: action %0d, timing %0d, lane %0d, other %0d",
                 action_errs, timing_errs, lane_errs, other_errs);
        if (action_errs + timing_errs + lane_errs + other_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, the run did not finish within %0d cycles", cycle_limit);
        $display("TB FAILED");
        $finish;
    end

    // out and out_valid settled at the falling edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (!was_valid) begin
                burst_cnt = 0;
                trk_lane  = int'(frame_init);
            end
            burst_cnt++;  // also the column just entered
            if (exp_q.size() == 0) begin
                other_errs++;
                $display("out_valid is high at %0t with no action left to expect", $time);
            end else begin
                exp_out = exp_q.pop_front();
            end
            case (out)
                subway_ctrl_pkg::act_right: begin
                    if (trk_lane == num_lanes - 1) begin
                        lane_errs++;
                        $display("right step from the last lane at %0t", $time);
                    end else begin
                        trk_lane++;
                    end
                end
                subway_ctrl_pkg::act_left: begin
                    if (trk_lane == 0) begin
                        lane_errs++;
                        $display("left step from lane 0 at %0t", $time);
                    end else begin
                        trk_lane--;
                    end
                end
                default: ;
            endcase
            a_off_train: assert (burst_cnt >= map_cols ||
                                 frame_map[burst_cnt][trk_lane] != subway_map_pkg::cell_train)
                else begin
                    lane_errs++;
                    $display("runner stands on a train at column %0d lane %0d", burst_cnt,
                             trk_lane);
                end
        end
        was_valid = out_valid;
    end

    a_reset_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> !out_valid && out == subway_ctrl_pkg::act_forward)
        else begin
            other_errs++;
            $display("ERROR %0t out_valid expected 0 got %0d, out expected 0 got %0d",
                     $time, $sampled(out_valid), $sampled(out));
        end

    a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !started |-> dut.u_run_ctrl.state == subway_ctrl_pkg::st_idle)
        else begin
            other_errs++;
            $display("ERROR %0t state expected %0d got %0d", $time,
                     subway_ctrl_pkg::st_idle, $sampled(dut.u_run_ctrl.state));
        end

    a_action: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> out == exp_out)
        else begin
            action_errs++;
            $display("ERROR %0t out expected %0d got %0d", $time, $sampled(exp_out),
                     $sampled(out));
        end

    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(in_valid) |-> ##4 $rose(out_valid))
        else begin
            timing_errs++;
            $display("out_valid did not rise on the fourth edge after the last column");
        end

    a_burst_len: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_valid) |-> burst_cnt == num_steps)
        else begin
            timing_errs++;
            $display("out_valid burst lasted %0d cycles instead of %0d", burst_cnt, num_steps);
        end

    a_end_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(out_valid) |-> dut.u_run_ctrl.state == subway_ctrl_pkg::st_idle)
        else begin
            timing_errs++;
            $display("ERROR %0t state expected %0d got %0d", $time,
                     subway_ctrl_pkg::st_idle, $sampled(dut.u_run_ctrl.state));
        end

endmodule

// ==== project.f ====
+incdir+sim
verilog/subway_map_pkg.sv
verilog/subway_ctrl_pkg.sv
verilog/map_buffer.sv
verilog/run_ctrl.sv
verilog/move_planner.sv
verilog/subway_top.sv
sim/tb_subway.sv

// ==== run.sh ====
#!/bin/sh
# build with Verilator, run, pass only when the pass line shows up
verilator --binary --assert -Wno-fatal --top-module tb_subway -Mdir obj_dir -f project.f \
    || { echo "verilator build failed"; exit 1; }
sim_out=$(./obj_dir/Vtb_subway)
echo "$sim_out"
echo "$sim_out" | grep -qx "TB PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
